/* hw/core_isa_pkg.sv */
// Instruction-level types for the execute and write-back slice
// Opcode values are fixed since the pattern file uses them in hex

package core_isa_pkg;

    // ==================================================
    // Data path width
    // ==================================================

    // RV32 word, not meant to be changed
    parameter int data_width = 32;

    // ==================================================
    // Pre-decoded operations
    // ==================================================

    typedef enum logic [3:0] {
        // Register-register forms
        OP_ADD     = 4'h0,
        OP_SUB     = 4'h1,
        OP_AND     = 4'h2,
        OP_OR      = 4'h3,
        OP_XOR     = 4'h4,
        OP_SLL     = 4'h5,
        OP_SRL     = 4'h6,
        OP_SRA     = 4'h7,
        OP_SLT     = 4'h8,
        OP_SLTU    = 4'h9,
        // Register-immediate forms, op_imm is operand b
        OP_ADDI    = 4'ha,
        OP_ANDI    = 4'hb,
        OP_ORI     = 4'hc,
        OP_XORI    = 4'hd,
        // Upper immediate, passed through as is
        OP_LUI     = 4'he,
        // Caught at write-back, freezes the slice
        OP_ILLEGAL = 4'hf
    } opcode_e;

endpackage

/* hw/core_pipe_pkg.sv */
// Pipeline control types shared by the sequencer and the ALU stage

package core_pipe_pkg;

    // ==================================================
    // Write-back sequencer
    // ==================================================

    typedef enum logic {
        // Normal operation
        WB_WRITE = 1'b0,
        // Illegal op seen, held until reset
        WB_CATCH = 1'b1
    } wb_state_e;

    // ==================================================
    // Operand source
    // ==================================================

    typedef enum logic {
        FWD_REGFILE = 1'b0,
        FWD_WB      = 1'b1
    } fwd_sel_e;

endpackage

/* hw/core_regfile.sv */
// Two async read ports, one write port; x0 reads zero
// Write data is visible to readers only after the write edge

`timescale 1ns/1ps

module core_regfile
    import core_isa_pkg::*;
#(
    parameter int reg_count = 32
) (
    input  logic                         clk,
    input  logic                         rstz,
    // Read ports
    input  logic [$clog2(reg_count)-1:0] rs1,
    input  logic [$clog2(reg_count)-1:0] rs2,
    output logic [data_width-1:0]        rdata1,
    output logic [data_width-1:0]        rdata2,
    // Write port
    input  logic                         wr_en,
    input  logic [$clog2(reg_count)-1:0] wr_sel,
    input  logic [data_width-1:0]        wr_data
);

    localparam int idx_w = $clog2(reg_count);

    logic [data_width-1:0] regs [reg_count];

    // ==================================================
    // Register array
    // ==================================================

    // Entries are cleared at reset
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_sel != idx_w'(0))) begin
            regs[wr_sel] <= wr_data;
        end
    end

    // x0 hard-wired regardless of array content
    assign rdata1 = (rs1 == idx_w'(0)) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == idx_w'(0)) ? '0 : regs[rs2];

    // ==================================================
    // Checks
    // ==================================================

    // ALU stage drops rd_write for x0, so the sequencer never asks for it
    a_no_x0_write: assert property (
        @(posedge clk) disable iff (!rstz)
        wr_en |-> (wr_sel != idx_w'(0))
    );

endmodule

/* hw/core_alu_stage.sv */
// Execute stage plus the EX/WB register; one result per accepted op
// Operand b of immediate forms and LUI always comes from op_imm

`timescale 1ns/1ps

module core_alu_stage
    import core_isa_pkg::*;
    import core_pipe_pkg::*;
#(
    parameter int reg_count = 32
) (
    input  logic                         clk,
    input  logic                         rstz,
    // Decoded operation
    input  opcode_e                      op_code,
    input  logic [$clog2(reg_count)-1:0] op_rd,
    input  logic [data_width-1:0]        op_imm,
    // Register file data
    input  logic [data_width-1:0]        rdata1,
    input  logic [data_width-1:0]        rdata2,
    // From the sequencer
    input  fwd_sel_e                     fwd_sel1,
    input  fwd_sel_e                     fwd_sel2,
    input  logic                         load_en,
    // EX/WB register
    output logic                         ex_vld,
    output logic [$clog2(reg_count)-1:0] ex_rd,
    output logic                         ex_rd_write,
    output logic                         ex_illegal,
    output logic [data_width-1:0]        ex_result
);

    localparam int idx_w = $clog2(reg_count);

    // Internal ALU function, several opcodes share one
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU, ALU_PASS
    } alu_fn_e;

    alu_fn_e               alu_fn;
    logic                  use_imm;
    logic                  is_illegal;
    logic [data_width-1:0] op_a;
    logic [data_width-1:0] op_b;
    logic [data_width-1:0] result;

    // ==================================================
    // Decode
    // ==================================================

    always_comb begin
        alu_fn     = ALU_ADD;
        use_imm    = 1'b0;
        is_illegal = 1'b0;
        case (op_code)
            OP_ADD:  alu_fn = ALU_ADD;
            OP_SUB:  alu_fn = ALU_SUB;
            OP_AND:  alu_fn = ALU_AND;
            OP_OR:   alu_fn = ALU_OR;
            OP_XOR:  alu_fn = ALU_XOR;
            OP_SLL:  alu_fn = ALU_SLL;
            OP_SRL:  alu_fn = ALU_SRL;
            OP_SRA:  alu_fn = ALU_SRA;
            OP_SLT:  alu_fn = ALU_SLT;
            OP_SLTU: alu_fn = ALU_SLTU;
            OP_ADDI: begin
                alu_fn  = ALU_ADD;
                use_imm = 1'b1;
            end
            OP_ANDI: begin
                alu_fn  = ALU_AND;
                use_imm = 1'b1;
            end
            OP_ORI: begin
                alu_fn  = ALU_OR;
                use_imm = 1'b1;
            end
            OP_XORI: begin
                alu_fn  = ALU_XOR;
                use_imm = 1'b1;
            end
            OP_LUI: begin
                alu_fn  = ALU_PASS;
                use_imm = 1'b1;
            end
            default: is_illegal = 1'b1;
        endcase
    end

    // ==================================================
    // Operands and ALU
    // ==================================================

    // Forwarded value is the op still waiting in EX/WB
    assign op_a = (fwd_sel1 == FWD_WB) ? ex_result : rdata1;
    assign op_b = use_imm ? op_imm : ((fwd_sel2 == FWD_WB) ? ex_result : rdata2);

    always_comb begin
        case (alu_fn)
            ALU_ADD:  result = op_a + op_b;
            ALU_SUB:  result = op_a - op_b;
            ALU_AND:  result = op_a & op_b;
            ALU_OR:   result = op_a | op_b;
            ALU_XOR:  result = op_a ^ op_b;
            // Shift amount is the low 5 bits only
            ALU_SLL:  result = op_a << op_b[4:0];
            ALU_SRL:  result = op_a >> op_b[4:0];
            ALU_SRA:  result = $unsigned($signed(op_a) >>> op_b[4:0]);
            ALU_SLT:  result = data_width'($signed(op_a) < $signed(op_b));
            ALU_SLTU: result = data_width'(op_a < op_b);
            default:  result = op_b;
        endcase
    end

    // ==================================================
    // EX/WB register
    // ==================================================

    // Valid only for the cycle after acceptance
    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            ex_vld      <= 1'b0;
            ex_rd_write <= 1'b0;
            ex_illegal  <= 1'b0;
        end else begin
            ex_vld <= load_en;
            if (load_en) begin
                ex_rd_write <= (op_rd != idx_w'(0)) && !is_illegal;
                ex_illegal  <= is_illegal;
            end
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        if (load_en) begin
            ex_rd     <= op_rd;
            ex_result <= result;
        end
    end

endmodule

/* hw/core_wb_ctrl.sv */
// Write-back sequencer; an illegal op in EX/WB locks the slice until reset
// No back-pressure other than the illegal catch

`timescale 1ns/1ps

module core_wb_ctrl
    import core_pipe_pkg::*;
#(
    parameter int reg_count = 32
) (
    input  logic                         clk,
    input  logic                         rstz,
    // Operation handshake
    input  logic                         op_vld,
    output logic                         op_rdy,
    input  logic [$clog2(reg_count)-1:0] op_rs1,
    input  logic [$clog2(reg_count)-1:0] op_rs2,
    // EX/WB register status
    input  logic                         ex_vld,
    input  logic [$clog2(reg_count)-1:0] ex_rd,
    input  logic                         ex_rd_write,
    input  logic                         ex_illegal,
    // Controls
    output logic                         load_en,
    output fwd_sel_e                     fwd_sel1,
    output fwd_sel_e                     fwd_sel2,
    output logic                         wr_en,
    output logic                         trap
);

    localparam int idx_w = $clog2(reg_count);

    wb_state_e        state;
    wb_state_e        next_state;
    logic             catch_now;
    logic             fwd_ok;
    logic [idx_w-1:0] pend_rd;

    // ==================================================
    // Sequencer
    // ==================================================

    // Illegal op sitting in EX/WB this cycle
    assign catch_now = ex_vld && ex_illegal;

    always_ff @(posedge clk or negedge rstz) begin
        if (!rstz) begin
            state <= WB_WRITE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            WB_WRITE: begin
                if (catch_now) begin
                    next_state = WB_CATCH;
                end
            end
            // Only reset leaves
            default: next_state = WB_CATCH;
        endcase
    end

    assign trap = (state == WB_CATCH);

    // ==================================================
    // Handshake and forwarding
    // ==================================================

    // Drops in the same cycle the illegal op shows up
    assign op_rdy  = (state == WB_WRITE) && !catch_now;
    assign load_en = op_vld && op_rdy;

    // Pending write not yet in the register file
    assign fwd_ok  = ex_vld && ex_rd_write;
    assign pend_rd = ex_rd;

    assign fwd_sel1 = (fwd_ok && (op_rs1 == pend_rd)) ? FWD_WB : FWD_REGFILE;
    assign fwd_sel2 = (fwd_ok && (op_rs2 == pend_rd)) ? FWD_WB : FWD_REGFILE;

    // Register write for a valid op with a real destination
    // EX/WB stays empty once caught since load_en follows op_rdy
    assign wr_en = ex_vld && ex_rd_write;

    // ==================================================
    // Checks
    // ==================================================

    a_no_write_in_catch: assert property (
        @(posedge clk) disable iff (!rstz)
        (state == WB_CATCH) |-> !wr_en
    );

    a_trap_sticky: assert property (
        @(posedge clk) disable iff (!rstz)
        trap |=> trap
    );

endmodule

/* hw/core_ex_wb_top.sv */
// Execute and write-back slice top; register count sets RV32I or RV32E
// Write-back port shows the EX/WB register one cycle after acceptance

`timescale 1ns/1ps

module core_ex_wb_top
    import core_isa_pkg::*;
    import core_pipe_pkg::*;
#(
    // 32 for RV32I, 16 for RV32E
    parameter int reg_count = 32
) (
    input  logic                         clk,
    input  logic                         rstz,
    // Operation port
    input  logic                         op_vld,
    output logic                         op_rdy,
    input  opcode_e                      op_code,
    input  logic [$clog2(reg_count)-1:0] op_rd,
    input  logic [$clog2(reg_count)-1:0] op_rs1,
    input  logic [$clog2(reg_count)-1:0] op_rs2,
    input  logic [data_width-1:0]        op_imm,
    // Write-back port
    output logic                         regwr_en,
    output logic [$clog2(reg_count)-1:0] regwr_sel,
    output logic [data_width-1:0]        regwr_data,
    output logic                         trap
);

    localparam int idx_w = $clog2(reg_count);

    logic [data_width-1:0] rdata1;
    logic [data_width-1:0] rdata2;
    fwd_sel_e              fwd_sel1;
    fwd_sel_e              fwd_sel2;
    logic                  load_en;
    logic                  wr_en;
    logic                  ex_vld;
    logic [idx_w-1:0]      ex_rd;
    logic                  ex_rd_write;
    logic                  ex_illegal;
    logic [data_width-1:0] ex_result;

    // ==================================================
    // Blocks
    // ==================================================

    core_regfile #(
        .reg_count (reg_count)
    ) core_regfile_inst (
        .clk     (clk),
        .rstz    (rstz),
        .rs1     (op_rs1),
        .rs2     (op_rs2),
        .rdata1  (rdata1),
        .rdata2  (rdata2),
        .wr_en   (wr_en),
        .wr_sel  (ex_rd),
        .wr_data (ex_result)
    );

    core_alu_stage #(
        .reg_count (reg_count)
    ) core_alu_stage_inst (
        .clk         (clk),
        .rstz        (rstz),
        .op_code     (op_code),
        .op_rd       (op_rd),
        .op_imm      (op_imm),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .fwd_sel1    (fwd_sel1),
        .fwd_sel2    (fwd_sel2),
        .load_en     (load_en),
        .ex_vld      (ex_vld),
        .ex_rd       (ex_rd),
        .ex_rd_write (ex_rd_write),
        .ex_illegal  (ex_illegal),
        .ex_result   (ex_result)
    );

    core_wb_ctrl #(
        .reg_count (reg_count)
    ) core_wb_ctrl_inst (
        .clk         (clk),
        .rstz        (rstz),
        .op_vld      (op_vld),
        .op_rdy      (op_rdy),
        .op_rs1      (op_rs1),
        .op_rs2      (op_rs2),
        .ex_vld      (ex_vld),
        .ex_rd       (ex_rd),
        .ex_rd_write (ex_rd_write),
        .ex_illegal  (ex_illegal),
        .load_en     (load_en),
        .fwd_sel1    (fwd_sel1),
        .fwd_sel2    (fwd_sel2),
        .wr_en       (wr_en),
        .trap        (trap)
    );

    // Write-back port mirrors the register file write
    assign regwr_en   = wr_en;
    assign regwr_sel  = ex_rd;
    assign regwr_data = ex_result;

endmodule

/* tb/core_tb.sv */
// Drives the ops of tb/core_patterns.txt and checks the write-back port every cycle
// Run from the project root; the last pattern must be OP_ILLEGAL

`timescale 1ns/1ps

module core_tb
    import core_isa_pkg::*;
();

    localparam int reg_count       = 32;
    localparam int idx_w           = $clog2(reg_count);
    localparam int pattern_count   = 38;
    localparam int field_count     = 6;
    localparam int reset_cycles    = 16;
    localparam int trap_cycles     = 20;
    localparam int watchdog_cycles = pattern_count * 5 + 100;

    logic                  clk;
    logic                  rstz;
    logic                  op_vld;
    logic                  op_rdy;
    opcode_e               op_code;
    logic [idx_w-1:0]      op_rd;
    logic [idx_w-1:0]      op_rs1;
    logic [idx_w-1:0]      op_rs2;
    logic [data_width-1:0] op_imm;
    logic                  regwr_en;
    logic [idx_w-1:0]      regwr_sel;
    logic [data_width-1:0] regwr_data;
    logic                  trap;

    // Six words per op: opcode, rd, rs1, rs2, imm, expected
    logic [31:0]           pat_mem [pattern_count * field_count];
    integer                seed;
    int                    error_count;
    int                    write_count;
    // Writes owed by ops accepted at the coming edge
    logic [idx_w-1:0]      exp_sel_q [$];
    logic [data_width-1:0] exp_data_q [$];

    core_ex_wb_top #(
        .reg_count (reg_count)
    ) core_ex_wb_top_inst (
        .clk        (clk),
        .rstz       (rstz),
        .op_vld     (op_vld),
        .op_rdy     (op_rdy),
        .op_code    (op_code),
        .op_rd      (op_rd),
        .op_rs1     (op_rs1),
        .op_rs2     (op_rs2),
        .op_imm     (op_imm),
        .regwr_en   (regwr_en),
        .regwr_sel  (regwr_sel),
        .regwr_data (regwr_data),
        .trap       (trap)
    );

    // ==================================================
    // Clock and watchdog
    // ==================================================

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout after %0d cycles, the run did not complete", watchdog_cycles);
        $display("TESTS FAILED");
        $finish;
    end

    // ==================================================
    // Per-cycle helpers
    // ==================================================

    // Called right after a falling edge, before any input moves
    task automatic check_writeback();
        logic [idx_w-1:0]      sel_exp;
        logic [data_width-1:0] data_exp;
        if (regwr_en) begin
            if (exp_sel_q.size() == 0) begin
                $display("Unexpected register write at %0t", $time);
                error_count++;
            end else begin
                sel_exp  = exp_sel_q.pop_front();
                data_exp = exp_data_q.pop_front();
                write_count++;
                if (regwr_sel !== sel_exp) begin
                    $display("Fail regwr_sel expected %h actual %h", sel_exp, regwr_sel);
                    error_count++;
                end
                if (regwr_data !== data_exp) begin
                    $display("Fail regwr_data expected %h actual %h", data_exp, regwr_data);
                    error_count++;
                end
            end
        end else if (exp_sel_q.size() != 0) begin
            // Latency is exactly one cycle, so a late write is an error
            $display("Register write missing one cycle after acceptance at %0t", $time);
            error_count++;
            exp_sel_q.delete();
            exp_data_q.delete();
        end
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        check_writeback();
        op_vld = 1'b0;
    endtask

    // Holds the op until accepted; op_rdy depends on registers only
    task automatic send_op(input opcode_e code, input logic [idx_w-1:0] rd,
                           input logic [idx_w-1:0] rs1, input logic [idx_w-1:0] rs2,
                           input logic [31:0] imm, input logic [31:0] exp_data);
        bit accepted;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            check_writeback();
            op_vld  = 1'b1;
            op_code = code;
            op_rd   = rd;
            op_rs1  = rs1;
            op_rs2  = rs2;
            op_imm  = imm;
            if (op_rdy) begin
                accepted = 1'b1;
                // x0 and illegal ops never write
                if ((rd != '0) && (code != OP_ILLEGAL)) begin
                    exp_sel_q.push_back(rd);
                    exp_data_q.push_back(exp_data);
                end
            end
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        op_vld = 1'b0;
        rstz   = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        rstz = 1'b1;
        exp_sel_q.delete();
        exp_data_q.delete();
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        int               gap;
        int               base;
        bit               dependent;
        logic             exp_trap;
        logic [idx_w-1:0] prev_rd;
        logic [idx_w-1:0] cur_rd;
        logic [idx_w-1:0] cur_rs1;
        logic [idx_w-1:0] cur_rs2;
        rstz        = 1'b0;
        op_vld      = 1'b0;
        op_code     = OP_ADD;
        op_rd       = '0;
        op_rs1      = '0;
        op_rs2      = '0;
        op_imm      = '0;
        seed        = 32'ha3f1;
        error_count = 0;
        write_count = 0;
        prev_rd     = '0;
        $readmemh("tb/core_patterns.txt", pat_mem);
        if (pat_mem[(pattern_count - 1) * field_count] != 32'hf) begin
            $display("Pattern file does not end with an illegal operation");
            error_count++;
        end
        apply_reset();

        for (int i = 0; i < pattern_count; i++) begin
            base    = i * field_count;
            cur_rd  = pat_mem[base + 1][idx_w-1:0];
            cur_rs1 = pat_mem[base + 2][idx_w-1:0];
            cur_rs2 = pat_mem[base + 3][idx_w-1:0];
            // Consumer of the previous result goes back to back
            dependent = (prev_rd != '0) && ((cur_rs1 == prev_rd) || (cur_rs2 == prev_rd));
            gap = $unsigned($random(seed)) % 4;
            if (dependent) begin
                gap = 0;
            end
            repeat (gap) idle_cycle();
            send_op(opcode_e'(pat_mem[base][3:0]), cur_rd, cur_rs1, cur_rs2,
                    pat_mem[base + 4], pat_mem[base + 5]);
            prev_rd = (pat_mem[base][3:0] == 4'hf) ? '0 : cur_rd;
        end

        // Valid ops keep coming after the illegal one
        for (int k = 0; k < trap_cycles; k++) begin
            @(negedge clk);
            check_writeback();
            op_vld   = 1'b1;
            op_code  = OP_ADDI;
            op_rd    = idx_w'(9);
            op_rs1   = '0;
            op_imm   = 32'h77;
            exp_trap = (k > 0);
            if (op_rdy !== 1'b0) begin
                $display("Fail op_rdy expected %h actual %h", 1'b0, op_rdy);
                error_count++;
            end
            if (trap !== exp_trap) begin
                $display("Fail trap expected %h actual %h", exp_trap, trap);
                error_count++;
            end
        end

        // Reset leaves the trap and clears the register file
        apply_reset();
        @(negedge clk);
        if (trap !== 1'b0) begin
            $display("Fail trap expected %h actual %h", 1'b0, trap);
            error_count++;
        end
        if (op_rdy !== 1'b1) begin
            $display("Fail op_rdy expected %h actual %h", 1'b1, op_rdy);
            error_count++;
        end
        send_op(OP_ADDI, idx_w'(7), '0, '0, 32'h5a5a, 32'h5a5a);
        idle_cycle();
        send_op(OP_ADD, idx_w'(8), idx_w'(7), idx_w'(7), '0, 32'hb4b4);
        // x5 held 0x12345678 before the reset
        send_op(OP_OR, idx_w'(9), idx_w'(5), '0, '0, 32'h0);
        idle_cycle();
        idle_cycle();

        $display("Checked %0d register writes, %0d errors", write_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* tb/core_patterns.txt */
// Columns: opcode rd rs1 rs2 imm expected, all hex
// Expected is ignored where rd is 0 or the op is illegal
// Immediates, forwarding on both operands
a 01 00 00 00000005 00000005
a 02 00 00 fffffff0 fffffff0
0 03 01 02 00000000 fffffff5
1 04 03 01 00000000 fffffff0
e 05 00 00 12345000 12345000
c 05 05 00 00000678 12345678
d 06 05 00 ffffffff edcba987
2 07 05 06 00000000 00000000
3 08 05 06 00000000 ffffffff
4 09 05 01 00000000 1234567d
b 0a 05 00 0000ff00 00005600
// Shift amount 0x24 uses only its low 5 bits
a 0c 00 00 00000024 00000024
5 0b 05 0c 00000000 23456780
6 0d 02 0c 00000000 0fffffff
7 0e 02 0c 00000000 ffffffff
7 0f 05 01 00000000 0091a2b3
6 10 06 01 00000000 076e5d4c
7 11 06 01 00000000 ff6e5d4c
8 12 02 01 00000000 00000001
9 13 02 01 00000000 00000000
8 14 01 02 00000000 00000000
9 15 01 02 00000000 00000001
8 16 02 0e 00000000 00000001
// Writes to x0 are dropped, x0 reads zero
a 00 01 00 00000055 00000000
0 17 00 01 00000000 00000005
0 00 05 06 00000000 00000000
3 18 00 00 00000000 00000000
// Chain, then a regfile read of x26 two ops later
a 1a 01 00 00000100 00000105
a 1a 1a 00 00000100 00000205
1 1b 1a 01 00000000 00000200
a 1c 00 00 00000001 00000001
0 1d 1a 00 00000000 00000205
1 1e 00 01 00000000 fffffffb
5 1f 1e 1c 00000000 fffffff6
0 1f 1f 1f 00000000 ffffffec
6 03 1e 1e 00000000 0000001f
b 04 03 00 0000000f 0000000f
// Illegal op with a real destination, must not write
f 05 01 02 00000000 00000000

/* tb.f */
hw/core_isa_pkg.sv
hw/core_pipe_pkg.sv
hw/core_regfile.sv
hw/core_alu_stage.sv
hw/core_wb_ctrl.sv
hw/core_ex_wb_top.sv
tb/core_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
# Exit status is 0 only when the log holds no failure report.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_exe=core_tb_sim
log_file=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module core_tb \
    -Mdir "$build_dir" -o "$sim_exe" \
    -f tb.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/$sim_exe" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TESTS FAILED" "$log_file"; then
    exit 1
fi
if ! grep -q "TESTS PASSED" "$log_file"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0
